// File: hw/nn_defs.svh
`ifndef NN_DEFS_SVH
`define NN_DEFS_SVH

// layer shape
`define NUM_INPUTS 4
`define NUM_NEURONS 3

// result queue depth, also the upstream's starting credits
`define RESULT_DEPTH 4
`define OUT_CREDITS 2

// weights packed as {w3, w2, w1, w0}
`define NEURON0_WEIGHTS {32'hBEE9EFD5, 32'hBF27ABDD, 32'h3F4F762E, 32'hBF44EBA1}
`define NEURON0_BIAS 32'h3E5290AF

`define NEURON1_WEIGHTS {32'hBF13346C, 32'hBDCE33B5, 32'h3DEF8094, 32'hBEA37BAE}
`define NEURON1_BIAS 32'h3E600CD2

`define NEURON2_WEIGHTS {32'hBE08AB98, 32'h3F0F6E21, 32'hBE28E519, 32'h3F0F562D}
`define NEURON2_BIAS 32'hBF0F5226

`endif

// File: hw/nnPkg.sv
`include "nn_defs.svh"

package nnPkg;

	// ==================================================
	// float words and fields
	// ==================================================

	// IEEE-754 single precision
	typedef logic [31:0] floatWord;

	// biased exponent
	typedef logic [7:0] expField;

	// mantissa with the hidden one
	typedef logic [23:0] mantField;

	// ==================================================
	// layer vectors
	// ==================================================

	// act[0] is the first activation
	typedef struct packed
	{
		floatWord [`NUM_INPUTS-1:0] act;
	} activationVec;

	// word[n] comes from neuron n
	typedef struct packed
	{
		floatWord [`NUM_NEURONS-1:0] word;
	} resultVec;

endpackage

// File: hw/floatMult.sv
`timescale 1ns/1ns

module floatMult
(
	input nnPkg::floatWord x,
	input nnPkg::floatWord y,
	output nnPkg::floatWord z
);
	import nnPkg::*;

	logic signZ;
	expField expX;
	expField expY;
	mantField mantX;
	mantField mantY;
	logic [47:0] product;
	mantField mantZ;
	// wide enough to see underflow below zero
	logic [9:0] expSum;

	always_comb
	begin
		signZ = x[31] ^ y[31];
		expX = x[30:23];
		expY = y[30:23];
		mantX = {1'b1, x[22:0]};
		mantY = {1'b1, y[22:0]};
		product = mantX * mantY;

		// product lies in [1, 4), one bit of normalize at most
		if (product[47])
		begin
			mantZ = product[47:24];
			expSum = {2'b00, expX} + {2'b00, expY} - 10'd126;
		end
		else
		begin
			mantZ = product[46:23];
			expSum = {2'b00, expX} + {2'b00, expY} - 10'd127;
		end
	end

	always_comb
	begin
		// zero or denormal operand
		if (expX == 8'd0 || expY == 8'd0)
			z = '0;
		// underflow flushes to +0
		else if (expSum[9] || expSum == 10'd0)
			z = '0;
		else if (expSum >= 10'd255)
			z = {signZ, 8'hFF, 23'd0};
		else
			z = {signZ, expSum[7:0], mantZ[22:0]};
	end

endmodule

// File: hw/floatAdder.sv
`timescale 1ns/1ns

module floatAdder
(
	input nnPkg::floatWord a,
	input nnPkg::floatWord b,
	output nnPkg::floatWord sum
);
	import nnPkg::*;

	floatWord bigOp;
	floatWord smallOp;
	expField expBig;
	expField expDiff;
	mantField mantBig;
	mantField mantSmall;
	logic [24:0] magSum;
	logic [4:0] leadPos;
	logic [4:0] shiftLeft;
	logic [24:0] normMant;
	logic [9:0] expOut;

	// ==================================================
	// align
	// ==================================================

	always_comb
	begin
		// magnitude order follows the bit pattern without the sign
		if (a[30:0] >= b[30:0])
		begin
			bigOp = a;
			smallOp = b;
		end
		else
		begin
			bigOp = b;
			smallOp = a;
		end
		expBig = bigOp[30:23];
		expDiff = expBig - smallOp[30:23];
		mantBig = {1'b1, bigOp[22:0]};
		// shifted-out bits are lost
		mantSmall = {1'b1, smallOp[22:0]} >> expDiff;
	end

	always_comb
	begin
		if (bigOp[31] == smallOp[31])
			magSum = {1'b0, mantBig} + {1'b0, mantSmall};
		else
			magSum = {1'b0, mantBig} - {1'b0, mantSmall};
	end

	// ==================================================
	// normalize
	// ==================================================

	// leading one search
	always_comb
	begin
		leadPos = '0;
		for (int i = 0; i < 25; i++)
		begin
			if (magSum[i])
				leadPos = 5'(i);
		end
	end

	always_comb
	begin
		shiftLeft = 5'd23 - leadPos;
		if (leadPos == 5'd24)
		begin
			// carry out of the add
			normMant = magSum >> 1;
			expOut = {2'b00, expBig} + 10'd1;
		end
		else
		begin
			normMant = magSum << shiftLeft;
			expOut = {2'b00, expBig} - {5'b00000, shiftLeft};
		end
	end

	always_comb
	begin
		// zero and denormal operands count as +0
		if (a[30:23] == 8'd0)
			sum = (b[30:23] == 8'd0) ? '0 : b;
		else if (b[30:23] == 8'd0)
			sum = a;
		// exact cancellation
		else if (magSum == '0)
			sum = '0;
		else if (expOut[9] || expOut == 10'd0)
			sum = '0;
		else if (expOut >= 10'd255)
			sum = {bigOp[31], 8'hFF, 23'd0};
		else
			sum = {bigOp[31], expOut[7:0], normMant[22:0]};
	end

endmodule

// File: hw/neuronNode.sv
`timescale 1ns/1ns
`include "nn_defs.svh"

module neuronNode
#(
	parameter logic [`NUM_INPUTS*32-1:0] WEIGHTS = '0,
	parameter nnPkg::floatWord BIAS = '0
)
(
	input logic clk,
	input logic reset,
	input logic validIn,
	input nnPkg::activationVec activations,
	output logic validOut,
	output nnPkg::floatWord resultOut
);
	import nnPkg::*;

	floatWord [`NUM_INPUTS-1:0] products;
	floatWord [`NUM_INPUTS-1:0] productReg;
	floatWord pairSum0;
	floatWord pairSum1;
	floatWord pairReg0;
	floatWord pairReg1;
	floatWord treeSum;
	floatWord treeReg;
	floatWord biasSum;
	// one bit per stage
	logic [3:0] validPipe;

	// ==================================================
	// stage 1, products
	// ==================================================

	for (genvar i = 0; i < `NUM_INPUTS; i++)
	begin : genMult
		floatMult mult
		(
			.x(activations.act[i]),
			.y(WEIGHTS[i*32 +: 32]),
			.z(products[i])
		);
	end

	// ==================================================
	// stages 2 and 3, adder tree
	// ==================================================

	floatAdder add01
	(
		.a(productReg[0]),
		.b(productReg[1]),
		.sum(pairSum0)
	);

	floatAdder add23
	(
		.a(productReg[2]),
		.b(productReg[3]),
		.sum(pairSum1)
	);

	floatAdder addTree
	(
		.a(pairReg0),
		.b(pairReg1),
		.sum(treeSum)
	);

	// ==================================================
	// stage 4, bias and ReLU
	// ==================================================

	floatAdder addBias
	(
		.a(treeReg),
		.b(BIAS),
		.sum(biasSum)
	);

	always_ff @(posedge clk)
	begin
		productReg <= products;
		pairReg0 <= pairSum0;
		pairReg1 <= pairSum1;
		treeReg <= treeSum;
		// negative results clamp to +0
		resultOut <= biasSum[31] ? '0 : biasSum;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[2:0], validIn};
	end

	assign validOut = validPipe[3];

endmodule

// File: hw/resultQueue.sv
`timescale 1ns/1ns
`include "nn_defs.svh"

module resultQueue
(
	input logic clk,
	input logic reset,
	input logic push,
	input nnPkg::resultVec pushData,
	input logic outCredit,
	output logic outValid,
	output nnPkg::resultVec outVector,
	output logic inCredit
);
	import nnPkg::*;

	localparam int PTR_W = $clog2(`RESULT_DEPTH);
	localparam int COUNT_W = $clog2(`RESULT_DEPTH + 1);
	localparam int CREDIT_W = $clog2(`OUT_CREDITS + 1);

	resultVec queueMem [`RESULT_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [COUNT_W-1:0] entryCount;
	// credits held toward the downstream
	logic [CREDIT_W-1:0] creditCount;
	logic queueEmpty;
	logic sending;

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`RESULT_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// ==================================================
	// send side
	// ==================================================

	assign queueEmpty = (entryCount == '0);
	assign sending = !queueEmpty && (creditCount != '0);
	assign outValid = sending;
	assign outVector = queueMem[rdPtr];
	// a freed entry goes back upstream at once
	assign inCredit = sending;

	// ==================================================
	// storage and counters
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (push)
			queueMem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			entryCount <= '0;
			creditCount <= CREDIT_W'(`OUT_CREDITS);
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (sending)
				rdPtr <= nextPtr(rdPtr);
			case ({push, sending})
				2'b10: entryCount <= entryCount + 1'b1;
				2'b01: entryCount <= entryCount - 1'b1;
				default: entryCount <= entryCount;
			endcase
			// send and return in one cycle cancel out
			case ({sending, outCredit})
				2'b10: creditCount <= creditCount - 1'b1;
				2'b01: creditCount <= creditCount + 1'b1;
				default: creditCount <= creditCount;
			endcase
		end
	end

endmodule

// File: hw/hiddenLayer.sv
`timescale 1ns/1ns
`include "nn_defs.svh"

module hiddenLayer
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::activationVec inVector,
	output logic inCredit,
	output logic outValid,
	output nnPkg::resultVec outVector,
	input logic outCredit
);
	import nnPkg::*;

	resultVec layerResult;
	// all neuron valids match, neuron 0 stands for them
	logic layerValid;

	// ==================================================
	// neurons
	// ==================================================

	neuronNode #(.WEIGHTS(`NEURON0_WEIGHTS), .BIAS(`NEURON0_BIAS)) neuron0
	(
		.clk(clk),
		.reset(reset),
		.validIn(inValid),
		.activations(inVector),
		.validOut(layerValid),
		.resultOut(layerResult.word[0])
	);

	neuronNode #(.WEIGHTS(`NEURON1_WEIGHTS), .BIAS(`NEURON1_BIAS)) neuron1
	(
		.clk(clk),
		.reset(reset),
		.validIn(inValid),
		.activations(inVector),
		.validOut(),
		.resultOut(layerResult.word[1])
	);

	neuronNode #(.WEIGHTS(`NEURON2_WEIGHTS), .BIAS(`NEURON2_BIAS)) neuron2
	(
		.clk(clk),
		.reset(reset),
		.validIn(inValid),
		.activations(inVector),
		.validOut(),
		.resultOut(layerResult.word[2])
	);

	// ==================================================
	// result queue
	// ==================================================

	resultQueue queue
	(
		.clk(clk),
		.reset(reset),
		.push(layerValid),
		.pushData(layerResult),
		.outCredit(outCredit),
		.outValid(outValid),
		.outVector(outVector),
		.inCredit(inCredit)
	);

endmodule

// File: testbench/clockGen.sv
`timescale 1ns/1ns

module clockGen
(
	output logic clk,
	output logic reset
);
	localparam int HALF_PERIOD = 20;

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	// reset spans the first two rising edges
	initial
	begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: testbench/hiddenLayer_properties.sv
`timescale 1ns/1ns
`include "nn_defs.svh"

module hiddenLayerProperties
#(
	parameter int COUNT_W = $clog2(`RESULT_DEPTH + 1)
)
(
	input logic clk,
	input logic reset,
	input logic push,
	input logic outCredit,
	input logic outValid,
	input logic inCredit,
	input logic [COUNT_W-1:0] entryCount
);
	int creditFails = 0;
	int fullFails = 0;
	int matchFails = 0;
	int resetFails = 0;
	int failCount;
	// credits granted by the downstream and not yet spent
	int creditModel;
	// entries pushed and not yet sent
	int entryModel;

	assign failCount = creditFails + fullFails + matchFails + resetFails;

	always @(posedge clk)
	begin
		if (reset)
		begin
			creditModel <= `OUT_CREDITS;
			entryModel <= 0;
		end
		else
		begin
			creditModel <= creditModel - int'(outValid) + int'(outCredit);
			entryModel <= entryModel + int'(push) - int'(outValid);
		end
	end

	sendNeedsCredit: assert property (@(posedge clk) disable iff (reset)
		creditModel == 0 |-> !outValid)
	else
	begin
		creditFails++;
		$error("outValid raised while the downstream credit counter is zero");
	end

	noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
		entryCount == COUNT_W'(`RESULT_DEPTH) |-> !push)
	else
	begin
		fullFails++;
		$error("push arrived while the result queue is full");
	end

	// a send happens whenever an entry waits and a credit is in hand
	creditFollowsSend: assert property (@(posedge clk) disable iff (reset)
		(inCredit == outValid) && (outValid == (entryModel != 0 && creditModel != 0)))
	else
	begin
		matchFails++;
		$error("inCredit or outValid disagrees with the queued entries and credits");
	end

	// outputs quiet right after reset
	quietAfterReset: assert property (@(posedge clk)
		reset |=> !outValid && !inCredit)
	else
	begin
		resetFails++;
		$error("outValid or inCredit high in the cycle after reset");
	end

endmodule

// File: testbench/layerChecker.sv
`timescale 1ns/1ns
`include "nn_defs.svh"

module layerChecker
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::activationVec inVector,
	input logic inCredit,
	input logic outValid,
	input nnPkg::resultVec outVector,
	input logic outCredit,
	input logic finalCheck,
	output int pendingCount,
	output int valueErrors,
	output int protocolErrors
);
	import nnPkg::*;

	localparam int LAYER_LATENCY = 5;
	localparam logic [`NUM_INPUTS*32-1:0] N0_WEIGHTS = `NEURON0_WEIGHTS;
	localparam logic [`NUM_INPUTS*32-1:0] N1_WEIGHTS = `NEURON1_WEIGHTS;
	localparam logic [`NUM_INPUTS*32-1:0] N2_WEIGHTS = `NEURON2_WEIGHTS;
	localparam floatWord N0_BIAS = `NEURON0_BIAS;
	localparam floatWord N1_BIAS = `NEURON1_BIAS;
	localparam floatWord N2_BIAS = `NEURON2_BIAS;

	resultVec expected[$];
	int issueCycle[$];
	bit timedFlag[$];
	int cycleCount;
	int sentCount;
	int returnedCount;
	int creditPulses;

	// ==================================================
	// reference arithmetic
	// ==================================================

	function automatic floatWord refMult(input floatWord x, input floatWord y);
		logic [47:0] prod;
		int e;
		if (x[30:23] == 8'd0 || y[30:23] == 8'd0)
			return 32'd0;
		prod = {24'd0, 1'b1, x[22:0]} * {24'd0, 1'b1, y[22:0]};
		e = int'(x[30:23]) + int'(y[30:23]) - 127;
		if (prod[47])
		begin
			prod = prod >> 1;
			e = e + 1;
		end
		if (e <= 0)
			return 32'd0;
		if (e >= 255)
			return {x[31] ^ y[31], 8'hFF, 23'd0};
		return {x[31] ^ y[31], e[7:0], prod[45:23]};
	endfunction

	function automatic floatWord refAdd(input floatWord a, input floatWord b);
		logic bigSign;
		int bigExp;
		int smallExp;
		int bigMant;
		int smallMant;
		int mag;
		int e;
		if (a[30:23] == 8'd0)
			return (b[30:23] == 8'd0) ? 32'd0 : b;
		if (b[30:23] == 8'd0)
			return a;
		if (a[30:23] > b[30:23] || (a[30:23] == b[30:23] && a[22:0] >= b[22:0]))
		begin
			bigSign = a[31];
			bigExp = int'(a[30:23]);
			bigMant = int'({1'b1, a[22:0]});
			smallExp = int'(b[30:23]);
			smallMant = int'({1'b1, b[22:0]});
		end
		else
		begin
			bigSign = b[31];
			bigExp = int'(b[30:23]);
			bigMant = int'({1'b1, b[22:0]});
			smallExp = int'(a[30:23]);
			smallMant = int'({1'b1, a[22:0]});
		end
		// alignment drops the low bits
		smallMant = (bigExp - smallExp > 24) ? 0 : smallMant >> (bigExp - smallExp);
		mag = (a[31] == b[31]) ? bigMant + smallMant : bigMant - smallMant;
		if (mag == 0)
			return 32'd0;
		e = bigExp;
		if (mag >= 32'h0100_0000)
		begin
			mag = mag >> 1;
			e = e + 1;
		end
		while (mag < 32'h0080_0000)
		begin
			mag = mag << 1;
			e = e - 1;
		end
		if (e <= 0)
			return 32'd0;
		if (e >= 255)
			return {bigSign, 8'hFF, 23'd0};
		return {bigSign, e[7:0], mag[22:0]};
	endfunction

	function automatic floatWord refNeuron(input activationVec vec,
		input logic [`NUM_INPUTS*32-1:0] weights, input floatWord bias);
		floatWord prod [`NUM_INPUTS];
		floatWord total;
		for (int i = 0; i < `NUM_INPUTS; i++)
			prod[i] = refMult(vec.act[i], weights[i*32 +: 32]);
		total = refAdd(refAdd(prod[0], prod[1]), refAdd(prod[2], prod[3]));
		total = refAdd(total, bias);
		// ReLU
		return total[31] ? 32'd0 : total;
	endfunction

	// ==================================================
	// scoreboard
	// ==================================================

	always @(posedge clk)
	begin
		resultVec want;
		int startCycle;
		bit wasTimed;
		if (reset)
		begin
			expected.delete();
			issueCycle.delete();
			timedFlag.delete();
			cycleCount = 0;
			sentCount = 0;
			returnedCount = 0;
			creditPulses = 0;
		end
		else
		begin
			cycleCount++;
			if (outValid)
			begin
				sentCount++;
				// a credit returned in this cycle does not count yet
				if (sentCount > `OUT_CREDITS + returnedCount)
				begin
					protocolErrors++;
					$display("outValid pulse %0d came without a downstream credit", sentCount);
				end
				if (expected.size() == 0)
				begin
					protocolErrors++;
					$display("outValid came with no result outstanding");
				end
				else
				begin
					want = expected.pop_front();
					startCycle = issueCycle.pop_front();
					wasTimed = timedFlag.pop_front();
					for (int n = 0; n < `NUM_NEURONS; n++)
					begin
						if (outVector.word[n] !== want.word[n])
						begin
							valueErrors++;
							$display("[FAIL] outVector neuron %0d: expected %08h, got %08h",
								n, want.word[n], outVector.word[n]);
						end
					end
					if (wasTimed && cycleCount - startCycle != LAYER_LATENCY)
					begin
						protocolErrors++;
						$display("result took %0d cycles on an idle layer instead of %0d",
							cycleCount - startCycle, LAYER_LATENCY);
					end
				end
			end
			if (inCredit !== outValid)
			begin
				protocolErrors++;
				$display("inCredit does not follow outValid in cycle %0d", cycleCount);
			end
			if (inCredit)
				creditPulses++;
			if (outCredit)
				returnedCount++;
			if (inValid)
			begin
				want.word[0] = refNeuron(inVector, N0_WEIGHTS, N0_BIAS);
				want.word[1] = refNeuron(inVector, N1_WEIGHTS, N1_BIAS);
				want.word[2] = refNeuron(inVector, N2_WEIGHTS, N2_BIAS);
				// idle layer with a credit in hand, so latency is fixed
				timedFlag.push_back(expected.size() == 0 &&
					`OUT_CREDITS + returnedCount - sentCount > 0);
				expected.push_back(want);
				issueCycle.push_back(cycleCount);
			end
			if (finalCheck)
			begin
				if (expected.size() != 0)
				begin
					protocolErrors++;
					$display("%0d results never came out of the layer", expected.size());
				end
				if (creditPulses != sentCount)
				begin
					protocolErrors++;
					$display("saw %0d inCredit pulses for %0d outValid pulses",
						creditPulses, sentCount);
				end
			end
		end
		pendingCount = expected.size();
	end

endmodule

// File: testbench/hiddenLayerTb.sv
`timescale 1ns/1ns
`include "nn_defs.svh"

module hiddenLayerTb;
	import nnPkg::*;

	localparam int DRIVE_DELAY = 2;
	localparam int WAIT_LIMIT = 200;

	// downstream credit return modes
	localparam int HOLD = 0;
	localparam int RANDOM = 1;
	localparam int PROMPT = 2;

	logic clk;
	logic reset;
	logic inValid;
	activationVec inVector;
	logic inCredit;
	logic outValid;
	resultVec outVector;
	logic outCredit;
	logic finalCheck;
	int pendingCount;
	int valueErrors;
	int protocolErrors;
	int flowErrors;
	int creditsLeft;
	int owedCredits;
	int returnMode;
	logic [31:0] lcgState;

	clockGen clocks
	(
		.clk(clk),
		.reset(reset)
	);

	hiddenLayer UUT
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inVector(inVector),
		.inCredit(inCredit),
		.outValid(outValid),
		.outVector(outVector),
		.outCredit(outCredit)
	);

	layerChecker scoreboard
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inVector(inVector),
		.inCredit(inCredit),
		.outValid(outValid),
		.outVector(outVector),
		.outCredit(outCredit),
		.finalCheck(finalCheck),
		.pendingCount(pendingCount),
		.valueErrors(valueErrors),
		.protocolErrors(protocolErrors)
	);

	bind resultQueue hiddenLayerProperties queueProps
	(
		.clk(clk),
		.reset(reset),
		.push(push),
		.outCredit(outCredit),
		.outValid(outValid),
		.inCredit(inCredit),
		.entryCount(entryCount)
	);

	// upstream credits and results still owed a credit downstream
	always @(posedge clk)
	begin
		if (reset)
		begin
			creditsLeft <= `RESULT_DEPTH;
			owedCredits <= 0;
		end
		else
		begin
			creditsLeft <= creditsLeft + int'(inCredit) - int'(inValid);
			owedCredits <= owedCredits + int'(outValid) - int'(outCredit);
		end
	end

	// ==================================================
	// stimulus helpers
	// ==================================================

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic floatWord randomFloat();
		logic [31:0] draw;
		logic [31:0] fraction;
		draw = nextRandom();
		fraction = nextRandom();
		// exponents from 2^-15 up to 2^16
		return {draw[31], 8'd112 + {3'd0, draw[30:26]}, fraction[31:9]};
	endfunction

	function automatic activationVec makeVector(input floatWord a0, input floatWord a1,
		input floatWord a2, input floatWord a3);
		activationVec vec;
		vec.act[0] = a0;
		vec.act[1] = a1;
		vec.act[2] = a2;
		vec.act[3] = a3;
		return vec;
	endfunction

	function automatic activationVec randomVector();
		return makeVector(randomFloat(), randomFloat(), randomFloat(), randomFloat());
	endfunction

	task automatic driveCycle(input logic valid, input activationVec vec);
		logic [31:0] draw;
		@(posedge clk);
		#DRIVE_DELAY;
		inValid = valid;
		inVector = vec;
		if (owedCredits == 0 || returnMode == HOLD)
			outCredit = 1'b0;
		else if (returnMode == PROMPT)
			outCredit = 1'b1;
		else
		begin
			draw = nextRandom();
			outCredit = draw[31];
		end
	endtask

	task automatic sendVector(input activationVec vec, output int waited);
		waited = 0;
		// the vector driven now still spends a credit at the next edge
		while (creditsLeft - int'(inValid) <= 0 && waited < WAIT_LIMIT)
		begin
			driveCycle(1'b0, '0);
			waited++;
		end
		if (creditsLeft - int'(inValid) <= 0)
		begin
			flowErrors++;
			$display("timed out waiting for an input credit");
		end
		else
			driveCycle(1'b1, vec);
	endtask

	task automatic settle();
		int waited;
		waited = 0;
		returnMode = PROMPT;
		driveCycle(1'b0, '0);
		while ((pendingCount != 0 || owedCredits != 0) && waited < WAIT_LIMIT)
		begin
			driveCycle(1'b0, '0);
			waited++;
		end
		if (pendingCount != 0 || owedCredits != 0)
		begin
			flowErrors++;
			$display("timed out waiting for the layer to drain");
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================

	initial
	begin
		int waited;
		int totalErrors;
		inValid = 1'b0;
		inVector = '0;
		outCredit = 1'b0;
		finalCheck = 1'b0;
		flowErrors = 0;
		returnMode = RANDOM;
		lcgState = 32'he2c5_bcdf;

		waited = 0;
		while (reset !== 1'b0 && waited < WAIT_LIMIT)
		begin
			driveCycle(1'b0, '0);
			waited++;
		end
		if (reset !== 1'b0)
		begin
			flowErrors++;
			$display("timed out waiting for reset to end");
		end

		// random traffic with random credit returns
		returnMode = RANDOM;
		for (int i = 0; i < 24; i++)
			sendVector(randomVector(), waited);
		settle();

		// negative sums clamp to zero
		sendVector(makeVector(32'h40800000, 32'd0, 32'd0, 32'd0), waited);
		sendVector(makeVector(32'hC0800000, 32'd0, 32'd0, 32'd0), waited);
		settle();

		// zeros and denormals act as +0
		sendVector(makeVector(32'd0, 32'd0, 32'd0, 32'd0), waited);
		sendVector(makeVector(32'h00000001, 32'h807FFFFF, 32'h00400000, 32'h80000000), waited);
		settle();

		// withhold downstream credits and release them later
		returnMode = HOLD;
		for (int i = 0; i < `RESULT_DEPTH; i++)
			sendVector(randomVector(), waited);
		repeat (20) driveCycle(1'b0, '0);
		settle();

		// single input on an idle layer
		sendVector(randomVector(), waited);
		settle();

		// a full window of input credits back to back
		for (int i = 0; i < `RESULT_DEPTH; i++)
		begin
			sendVector(randomVector(), waited);
			if (waited != 0)
			begin
				flowErrors++;
				$display("input credits ran out inside a full window");
			end
		end
		settle();

		finalCheck = 1'b1;
		driveCycle(1'b0, '0);
		finalCheck = 1'b0;
		driveCycle(1'b0, '0);

		totalErrors = valueErrors + protocolErrors + flowErrors + UUT.queue.queueProps.failCount;
		$display("Error counts: value %0d, protocol %0d, flow %0d, assertion %0d",
			valueErrors, protocolErrors, flowErrors, UUT.queue.queueProps.failCount);
		if (totalErrors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: hiddenLayer.f
+incdir+hw
hw/nnPkg.sv
hw/floatMult.sv
hw/floatAdder.sv
hw/neuronNode.sv
hw/resultQueue.sv
hw/hiddenLayer.sv
testbench/clockGen.sv
testbench/hiddenLayer_properties.sv
testbench/layerChecker.sv
testbench/hiddenLayerTb.sv

// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ns
TOP = hiddenLayerTb
FILELIST = hiddenLayer.f
SIM_ARGS = +verilator+error+limit+1000
LOG = sim.log
FAIL_MSG = Finished with errors

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
